// File: verilog/calca_pkg.sv
// CALCA address path shared definitions
// CPU and memory address types, data word, ECCR IOX decode constants
// and the MCLK sequencer state encoding
`default_nettype none

package calca_pkg;

  // CPU address as carried on ICA and LCA
  typedef logic [15:0] cpu_addr_t;

  // Memory word address, MCA bits 9..0 only
  typedef logic [9:0] mem_addr_t;

  // One bus data word
  typedef logic [15:0] data_t;

  // TRR ECCR = IOX 100115 octal
  // 1000_0000_0100_1101 binary
  parameter cpu_addr_t ECCR_IOX_ADDR = 16'o100115;

  // Upper decode covers bits 15..10 (the ECCR HI part)
  parameter cpu_addr_t ECCR_HI_MASK = 16'hfc00;

  // MCLK cycle sequencer states
  typedef enum logic [2:0] {
    IDLE,      // Waiting for host req
    MCLK_LO,   // MCLK low, MCA latch open
    MCLK_HI,   // MCLK high, MCA held, LCA loaded at rise
    WAIT_ACC,  // Waiting on the target
    ACK        // ack high until req drops
  } seq_state_t;

endpackage

`default_nettype wire

// File: verilog/mclk_cycle_seq.sv
// MCLK cycle sequencer
// Takes one host access per four-phase req/ack handshake, presents ICA
// and generates the MCLK low and high phases as sysclk-enabled states
`default_nettype none

module mclk_cycle_seq #(
  parameter int MCLK_HALF = 2  // sysclk cycles per MCLK phase
) (
  input  wire                         sysclk,
  input  wire                         arst_n,

  // Host side
  input  wire                         req,
  input  wire                         write,
  input  wire                         iox,
  input  wire  calca_pkg::cpu_addr_t  addr,
  input  wire  calca_pkg::data_t      wdata,
  output logic                        ack,
  output calca_pkg::data_t            rdata,

  // To address capture
  output calca_pkg::cpu_addr_t        ica,        // Held for the whole cycle
  output logic                        mclk,       // Memory clock phase
  output logic                        mclk_rise,  // One sysclk at MCLK rise

  // To / from target
  output logic                        acc_write,
  output logic                        acc_iox,
  output calca_pkg::data_t            acc_wdata,
  input  wire                         acc_done,
  input  wire  calca_pkg::data_t      acc_rdata
);

  localparam int CNT_W = (MCLK_HALF > 1) ? $clog2(MCLK_HALF) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MCLK_HALF - 1);  // Last cycle of a phase

  calca_pkg::seq_state_t state;
  logic [CNT_W-1:0]      phase_cnt;  // Position within MCLK phase
  logic                  done_seen;  // Target finished before WAIT_ACC
  logic                  start;      // New host access taken

  assign start = (state == calca_pkg::IDLE) && req;

  // Control FSM and MCLK generation
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= calca_pkg::IDLE;
      phase_cnt <= '0;
      mclk      <= 1'b1;  // MCLK idles high
      mclk_rise <= 1'b0;
      done_seen <= 1'b0;
      ack       <= 1'b0;
    end else begin
      mclk_rise <= 1'b0;                 // Strobe by default
      if (acc_done) done_seen <= 1'b1;   // Long MCLK_HI can overlap the target
      case (state)
        calca_pkg::IDLE: begin
          if (req) begin
            state     <= calca_pkg::MCLK_LO;
            mclk      <= 1'b0;           // Open MCA latch
            phase_cnt <= '0;
            done_seen <= 1'b0;
          end
        end
        calca_pkg::MCLK_LO: begin
          if (phase_cnt == CNT_LAST) begin
            state     <= calca_pkg::MCLK_HI;
            mclk      <= 1'b1;
            mclk_rise <= 1'b1;           // LCA loads on this one
            phase_cnt <= '0;
          end else begin
            phase_cnt <= phase_cnt + 1'b1;
          end
        end
        calca_pkg::MCLK_HI: begin
          if (phase_cnt == CNT_LAST) begin
            state     <= calca_pkg::WAIT_ACC;
            phase_cnt <= '0;
          end else begin
            phase_cnt <= phase_cnt + 1'b1;
          end
        end
        calca_pkg::WAIT_ACC: begin
          if (acc_done || done_seen) begin
            state <= calca_pkg::ACK;
            ack   <= 1'b1;
          end
        end
        calca_pkg::ACK: begin
          // Slow host holding req keeps us here
          if (!req) begin
            state <= calca_pkg::IDLE;
            ack   <= 1'b0;
          end
        end
        default: state <= calca_pkg::IDLE;
      endcase
    end
  end

  // Access fields, captured once per handshake
  always_ff @(posedge sysclk) begin
    if (start) begin
      ica       <= addr;
      acc_write <= write;
      acc_iox   <= iox;
      acc_wdata <= wdata;
    end
    if (acc_done) rdata <= acc_rdata;  // Valid by the time ack rises
  end

  // CPU address must not move between MCLK_LO and the end of ACK
  ica_stable_a : assert property (@(posedge sysclk) disable iff (!arst_n)
    (state != calca_pkg::IDLE && $past(state) != calca_pkg::IDLE) |-> $stable(ica))
    else $error("ica changed during an access cycle");

endmodule

`default_nettype wire

// File: verilog/addr_capture.sv
// CALCA address capture
// Latches MCA while MCLK is low, loads LCA at MCLK rise and
// decodes the ECCR IOX address 100115 octal
`default_nettype none

module addr_capture (
  input  wire                         sysclk,
  input  wire                         arst_n,

  input  wire  calca_pkg::cpu_addr_t  ica,        // CPU address in
  input  wire                         mclk,       // Memory clock phase
  input  wire                         mclk_rise,  // MCLK rising edge strobe

  output calca_pkg::mem_addr_t        mca,        // Memory address, bits 9..0
  output calca_pkg::cpu_addr_t        lca,        // Local address
  output logic                        eccr_sel,   // TRR ECCR decode
  output logic                        lca_valid   // LCA and eccr_sel settled
);

  calca_pkg::cpu_addr_t held_addr;  // Latch output incl. bits 15..10
  logic                 eccr_hi;    // Bits 15..10 match
  logic                 eccr_lo;    // Bits 9..0 match

  // Latch stand-in, transparent while MCLK low
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      held_addr <= '0;
    end else if (!mclk) begin
      held_addr <= ica;
    end
  end

  assign mca = held_addr[9:0];  // Upper bits never reach memory

  // Upper decode, folded in here from the LA block
  assign eccr_hi =
    ((held_addr ^ calca_pkg::ECCR_IOX_ADDR) & calca_pkg::ECCR_HI_MASK) == '0;

  // Lower ten bits against 0001001101
  assign eccr_lo = held_addr[9:0] == calca_pkg::ECCR_IOX_ADDR[9:0];

  // LCA register, edge-triggered on MCLK rise
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      lca       <= '0;
      eccr_sel  <= 1'b0;
      lca_valid <= 1'b0;
    end else begin
      lca_valid <= mclk_rise;  // One cycle after the rise
      if (mclk_rise) begin
        lca      <= held_addr;
        eccr_sel <= eccr_hi && eccr_lo;  // Decode of the value entering LCA
      end
    end
  end

  // MCA holds for every MCLK-high cycle after the first
  mca_hold_a : assert property (@(posedge sysclk) disable iff (!arst_n)
    (mclk && $past(mclk)) |-> $stable(mca))
    else $error("mca changed while MCLK high");

endmodule

`default_nettype wire

// File: verilog/mem_iox_target.sv
// Memory and IOX target
// Serves a 1K-word memory at MCA, the ECCR register on its IOX decode,
// and reads zero for any other IOX address
`default_nettype none

module mem_iox_target (
  input  wire                         sysclk,
  input  wire                         arst_n,

  // From address capture
  input  wire  calca_pkg::mem_addr_t  mca,
  input  wire                         eccr_sel,
  input  wire                         lca_valid,

  // Access fields from the sequencer
  input  wire                         acc_write,
  input  wire                         acc_iox,
  input  wire  calca_pkg::data_t      acc_wdata,

  output logic                        acc_done,   // One-cycle completion
  output calca_pkg::data_t            acc_rdata,
  output calca_pkg::data_t            eccr_q      // ECCR contents
);

  localparam int MEM_WORDS = 2 ** $bits(calca_pkg::mem_addr_t);

  calca_pkg::data_t mem [MEM_WORDS];  // Word memory, no reset

  logic mem_acc;   // Memory cycle
  logic eccr_acc;  // ECCR cycle
  logic eccr_wr;

  assign mem_acc  = lca_valid && !acc_iox;
  assign eccr_acc = lca_valid && acc_iox && eccr_sel;
  assign eccr_wr  = eccr_acc && acc_write;

  // Completion strobe and ECCR register
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      acc_done <= 1'b0;
      eccr_q   <= '0;
    end else begin
      acc_done <= lca_valid;
      if (eccr_wr) eccr_q <= acc_wdata;
    end
  end

  // Memory write port
  always_ff @(posedge sysclk) begin
    if (mem_acc && acc_write) begin
      mem[mca] <= acc_wdata;
    end
  end

  // Read data, loaded with the access
  always_ff @(posedge sysclk) begin
    if (lca_valid) begin
      if (acc_write) begin
        acc_rdata <= acc_wdata;   // Writes echo the data
      end else if (!acc_iox) begin
        acc_rdata <= mem[mca];
      end else if (eccr_sel) begin
        acc_rdata <= eccr_q;
      end else begin
        acc_rdata <= '0;          // Unknown IOX address
      end
    end
  end

  // One access in flight, so lca_valid never meets acc_done
  no_overlap_a : assert property (@(posedge sysclk) disable iff (!arst_n)
    acc_done |-> !lca_valid)
    else $error("lca_valid arrived with acc_done high");

endmodule

`default_nettype wire

// File: verilog/calca_subsys_top.sv
// CALCA address path subsystem
// Host port in front of the MCLK sequencer, address capture and
// memory / IOX target
`default_nettype none

module calca_subsys_top #(
  parameter int MCLK_HALF = 2  // sysclk cycles per MCLK phase
) (
  input  wire                         sysclk,
  input  wire                         arst_n,

  // Host port, four-phase req/ack
  input  wire                         req,
  input  wire                         write,
  input  wire                         iox,
  input  wire  calca_pkg::cpu_addr_t  addr,
  input  wire  calca_pkg::data_t      wdata,
  output wire                         ack,
  output wire  calca_pkg::data_t      rdata,
  output wire  calca_pkg::data_t      eccr_q
);

  calca_pkg::cpu_addr_t ica;
  calca_pkg::mem_addr_t mca;
  calca_pkg::data_t     acc_wdata;
  calca_pkg::data_t     acc_rdata;
  logic                 mclk;
  logic                 mclk_rise;
  logic                 eccr_sel;
  logic                 lca_valid;
  logic                 acc_write;
  logic                 acc_iox;
  logic                 acc_done;

  mclk_cycle_seq #(
    .MCLK_HALF (MCLK_HALF)
  ) u_seq (
    .sysclk    (sysclk),
    .arst_n    (arst_n),
    .req       (req),
    .write     (write),
    .iox       (iox),
    .addr      (addr),
    .wdata     (wdata),
    .ack       (ack),
    .rdata     (rdata),
    .ica       (ica),
    .mclk      (mclk),
    .mclk_rise (mclk_rise),
    .acc_write (acc_write),
    .acc_iox   (acc_iox),
    .acc_wdata (acc_wdata),
    .acc_done  (acc_done),
    .acc_rdata (acc_rdata)
  );

  addr_capture u_calca (
    .sysclk    (sysclk),
    .arst_n    (arst_n),
    .ica       (ica),
    .mclk      (mclk),
    .mclk_rise (mclk_rise),
    .mca       (mca),
    .lca       (),           // Only its ECCR decode leaves the block
    .eccr_sel  (eccr_sel),
    .lca_valid (lca_valid)
  );

  mem_iox_target u_target (
    .sysclk    (sysclk),
    .arst_n    (arst_n),
    .mca       (mca),
    .eccr_sel  (eccr_sel),
    .lca_valid (lca_valid),
    .acc_write (acc_write),
    .acc_iox   (acc_iox),
    .acc_wdata (acc_wdata),
    .acc_done  (acc_done),
    .acc_rdata (acc_rdata),
    .eccr_q    (eccr_q)
  );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// Testbench clock source
// Free-running clock, period in ns set by parameter
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 40  // Full clock period
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;  // First rising edge at half a period
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: tests/calca_subsys_tb.sv
// CALCA address path testbench
// Runs file-driven host accesses through the four-phase req/ack port,
// checks read data, ECCR contents and the handshake order
`default_nettype none

module calca_subsys_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    MCLK_HALF = 2;                    // Sysclk cycles per MCLK phase
  localparam int    HS_LIMIT  = 4 * MCLK_HALF + 20;   // Cycles allowed per handshake phase
  localparam string DATA_FILE = "tests/calca_testdata.txt";

  wire         sysclk;
  logic        arst_n;
  logic        req;
  logic        write;
  logic        iox;
  logic [15:0] addr;
  logic [15:0] wdata;
  wire         ack;
  wire  [15:0] rdata;
  wire  [15:0] eccr_q;

  // Vectors from the data file
  logic        v_write [$];
  logic        v_iox   [$];
  logic [15:0] v_addr  [$];
  logic [15:0] v_wdata [$];
  logic [15:0] v_rdata [$];

  logic [15:0] eccr_model;       // Expected ECCR contents
  int          cycle_cnt   = 0;  // Sysclk cycles since start
  int          cycle_limit = 0;  // Zero until the vectors are loaded

  tb_clock #(.PERIOD_NS(40)) u_clock (.clk(sysclk));

  calca_subsys_top #(.MCLK_HALF(MCLK_HALF)) uut (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .req    (req),
    .write  (write),
    .iox    (iox),
    .addr   (addr),
    .wdata  (wdata),
    .ack    (ack),
    .rdata  (rdata),
    .eccr_q (eccr_q)
  );

  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Columns: write iox addr wdata rdata, hex; lines starting with # are skipped
  task automatic load_vectors();
    int               fd;
    int               n;
    logic             done;
    logic [8*128-1:0] skip_buf;
    logic             w;
    logic             x;
    logic [15:0]      a;
    logic [15:0]      d;
    logic [15:0]      r;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open vector file %s", DATA_FILE);
      abort_run();
    end
    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, "%h %h %h %h %h\n", w, x, a, d, r);
      if (n == 5) begin
        v_write.push_back(w);
        v_iox.push_back(x);
        v_addr.push_back(a);
        v_wdata.push_back(d);
        v_rdata.push_back(r);
      end else if (n == -1) begin
        done = 1'b1;                                  // End of file
      end else if (n == 0) begin
        if ($fgets(skip_buf, fd) == 0) done = 1'b1;   // Comment line
      end else begin
        $display("Malformed line after vector %0d in %s", v_addr.size(), DATA_FILE);
        abort_run();
      end
    end
    $fclose(fd);
    if (v_addr.size() == 0) begin
      $display("No vectors found in %s", DATA_FILE);
      abort_run();
    end
  endtask

  // Quiet bus, ack must stay low
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge sysclk);
      check_value("ack", 16'(ack), 16'h0000);
    end
  endtask

  // One full four-phase handshake for vector idx
  task automatic run_access(input int idx);
    int wait_cnt;
    int hold_n;
    @(negedge sysclk);
    check_value("ack", 16'(ack), 16'h0000);  // Previous handshake closed
    write = v_write[idx];
    iox   = v_iox[idx];
    addr  = v_addr[idx];
    wdata = v_wdata[idx];
    req   = 1'b1;
    // Decoded IOX write to 100115 octal loads ECCR
    if (v_write[idx] && v_iox[idx] && v_addr[idx] == 16'h804d) eccr_model = v_wdata[idx];

    wait_cnt = 0;
    while (ack !== 1'b1) begin
      if (wait_cnt == HS_LIMIT) begin
        $display("Handshake error at %0t ns: no ack for vector %0d", $time, idx);
        abort_run();
      end
      @(negedge sysclk);
      wait_cnt++;
    end
    check_value("rdata", rdata, v_rdata[idx]);
    check_value("eccr_q", eccr_q, eccr_model);

    // Slow host, ack has to wait for req
    hold_n = $urandom % 3;
    repeat (hold_n) begin
      @(negedge sysclk);
      check_value("ack", 16'(ack), 16'h0001);
    end
    req = 1'b0;

    wait_cnt = 0;
    do begin
      if (wait_cnt == HS_LIMIT) begin
        $display("Handshake error at %0t ns: ack stuck high, vector %0d", $time, idx);
        abort_run();
      end
      @(negedge sysclk);
      wait_cnt++;
    end while (ack !== 1'b0);
    check_value("eccr_q", eccr_q, eccr_model);
  endtask

  // Run-length guard
  always @(posedge sysclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: run went past %0d clock cycles", cycle_limit);
      abort_run();
    end
  end

  initial begin
    arst_n     = 1'b0;
    req        = 1'b0;
    write      = 1'b0;
    iox        = 1'b0;
    addr       = 16'h0000;
    wdata      = 16'h0000;
    eccr_model = 16'h0000;  // ECCR clears on reset
    void'($urandom(68));

    load_vectors();
    cycle_limit = v_addr.size() * (2 * MCLK_HALF + 10) + 100;

    repeat (4) @(posedge sysclk);
    @(negedge sysclk);
    arst_n = 1'b1;
    check_value("ack", 16'(ack), 16'h0000);
    check_value("eccr_q", eccr_q, 16'h0000);
    idle_cycles(2);

    foreach (v_addr[i]) begin
      run_access(i);
      idle_cycles($urandom % 4);  // 0 to 3 idle cycles
    end

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/calca_testdata.txt
# Columns: write iox addr wdata rdata, all hex
# rdata is the expected read data, a write returns its own wdata
1 0 0010 1234 1234
0 0 0010 0000 1234
1 0 03ff a5a5 a5a5
0 0 03ff 0000 a5a5
1 0 0123 beef beef
0 0 fd23 0000 beef
1 0 8523 cafe cafe
0 0 0123 0000 cafe
0 1 804d 0000 0000
1 1 804d 5a3c 5a3c
0 1 804d 0000 5a3c
1 1 c04d 1111 1111
1 1 844d 2222 2222
1 1 804c 3333 3333
1 1 824d 4444 4444
1 1 004d 5555 5555
0 1 c04d 0000 0000
0 1 804c 0000 0000
0 1 824d 0000 0000
0 1 804d 0000 5a3c
1 0 004d 7777 7777
0 1 804d 0000 5a3c
1 1 804d 9999 9999
0 0 004d 0000 7777
0 0 804d 0000 7777
0 1 804d 0000 9999

// File: list.f
verilog/calca_pkg.sv
verilog/mclk_cycle_seq.sv
verilog/addr_capture.sv
verilog/mem_iox_target.sv
verilog/calca_subsys_top.sv
tests/tb_clock.sv
tests/calca_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CALCA address path testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module calca_subsys_tb -o calca_sim
./obj_dir/calca_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "tests failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation PASSED"
